// File: verilog/audio_settings.svh
// width and depth settings of the audio playback path that the package and the RTL include
`ifndef AUDIO_SETTINGS_SVH
`define AUDIO_SETTINGS_SVH

// memory side
`define AUDIO_ADDR_W        16      // word address into the shared memory

// period timer and sample length
`define AUDIO_PERIOD_W      15      // period counts clocks minus one and length counts words

// output side
`define AUDIO_DAC_W         8       // unsigned level into each pulse-density DAC

// number of sample words held ahead of playback
`define AUDIO_BUF_WORDS     3

`endif

// File: verilog/audio_pkg.sv
// shared types of the audio playback path that every RTL file references by scoped name
`default_nettype none

`include "audio_settings.svh"

package audio_pkg;

    typedef logic [`AUDIO_ADDR_W-1:0]   addr_t;     // memory word address
    typedef logic [15:0]                word_t;     // two samples, high byte plays first
    typedef logic [`AUDIO_PERIOD_W-1:0] count_t;    // period minus one, or length in words
    typedef logic signed [7:0]          sample_t;   // two's-complement sample
    typedef logic signed [7:0]          vol_t;      // 64 is unity gain
    typedef logic [`AUDIO_DAC_W-1:0]    level_t;    // 0x80 is silence

    // per-side volume with left in the upper byte
    typedef struct packed {
        vol_t   left;
        vol_t   right;
    } chan_vol_t;

    // channel setup as it arrives at the top level
    typedef struct packed {
        chan_vol_t  vol;
        count_t     period;
        addr_t      start;
        count_t     len;
    } chan_cfg_t;

    typedef enum logic [0:0] {
        MIX_LOAD    = 1'b0,     // register multiplier operands
        MIX_SCALE   = 1'b1      // form both levels from the products
    } mix_state_t;

endpackage

`default_nettype wire

// File: verilog/audio_fetch.sv
// fetch engine that requests sample words on memory slots and feeds the mixer one byte per step
`default_nettype none
`timescale 1ns/1ps

`include "audio_settings.svh"

module audio_fetch (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               enable_i,
    input  wire audio_pkg::addr_t   start_i,
    input  wire audio_pkg::count_t  len_i,
    input  wire logic               slot_start_i,
    input  wire logic               slot_end_i,
    input  wire audio_pkg::word_t   word_i,
    input  wire logic               step_i,
    output logic                    fetch_o,
    output audio_pkg::addr_t        addr_o,
    output audio_pkg::sample_t      sample_o
);

    localparam int BUF_WORDS = `AUDIO_BUF_WORDS;

    audio_pkg::addr_t       addr_q;                 // address of the next word to request
    audio_pkg::count_t      remain_q;               // words left before wrapping to start
    logic                   enable_q;
    logic                   fetch_q;
    logic                   low_sel_q;              // head word is on its low byte
    audio_pkg::word_t       buf_q [BUF_WORDS];      // entry 0 is the head
    logic [BUF_WORDS-1:0]   valid_q;

    audio_pkg::word_t       buf_d [BUF_WORDS];
    logic [BUF_WORDS-1:0]   valid_d;
    audio_pkg::word_t       head;

    logic                   restart;
    logic                   capture;
    logic                   consume;
    logic                   pop;
    logic                   slot_ok;
    logic                   wrap;

    assign restart = enable_i && !enable_q;                 // enable rising edge
    assign capture = enable_i && fetch_q && slot_end_i;     // slot end without request is ignored
    assign consume = step_i && valid_q[0];                  // step on an empty buffer does nothing
    assign pop     = consume && low_sel_q;                  // word leaves after its low byte
    assign slot_ok = enable_i && slot_start_i && !valid_q[BUF_WORDS-1];
    assign wrap    = (remain_q == '0);

    // shift out the head word, then drop a captured word into the first free entry
    always_comb begin : buf_next
        logic placed;

        placed  = 1'b0;
        buf_d   = buf_q;
        valid_d = valid_q;
        if (pop) begin
            for (int i = 0; i < BUF_WORDS - 1; i++) begin
                buf_d[i] = buf_q[i + 1];
            end
            valid_d = valid_q >> 1;
        end
        if (capture) begin
            for (int i = 0; i < BUF_WORDS; i++) begin
                if (!valid_d[i] && !placed) begin
                    buf_d[i]   = word_i;
                    valid_d[i] = 1'b1;
                    placed     = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q  <= 1'b0;
            fetch_q   <= 1'b0;
            low_sel_q <= 1'b0;
            valid_q   <= '0;
        end else begin
            enable_q <= enable_i;
            if (!enable_i) begin
                fetch_q   <= 1'b0;              // drop any open request
                low_sel_q <= 1'b0;
                valid_q   <= '0;
            end else begin
                valid_q <= valid_d;
                if (capture) begin
                    fetch_q <= 1'b0;
                end else if (slot_ok) begin
                    fetch_q <= 1'b1;
                end
                if (consume) begin
                    low_sel_q <= !low_sel_q;
                end
            end
        end
    end

    // word data and the looping address walk
    always_ff @(posedge clk) begin
        buf_q <= buf_d;
        if (reset_i || restart) begin
            addr_q   <= start_i;
            remain_q <= len_i - 1'b1;
        end else if (capture) begin
            if (wrap) begin
                addr_q   <= start_i;            // loop back at the end of the region
                remain_q <= len_i - 1'b1;
            end else begin
                addr_q   <= addr_q + 1'b1;
                remain_q <= remain_q - 1'b1;
            end
        end
    end

    assign head = buf_q[0];

    always_comb begin
        if (!valid_q[0]) begin
            sample_o = '0;                      // nothing buffered yet
        end else if (low_sel_q) begin
            sample_o = audio_pkg::sample_t'(head[7:0]);
        end else begin
            sample_o = audio_pkg::sample_t'(head[15:8]);
        end
    end

    assign fetch_o = fetch_q;
    assign addr_o  = addr_q;                    // steady while the request is open

endmodule

`default_nettype wire

// File: verilog/audio_mixer.sv
// sample rate timer and volume mixer that turn buffered samples into left and right DAC levels
`default_nettype none
`timescale 1ns/1ps

`include "audio_settings.svh"

module audio_mixer (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   enable_i,
    input  wire audio_pkg::count_t      period_i,
    input  wire audio_pkg::chan_vol_t   vol_i,
    input  wire audio_pkg::sample_t     sample_i,
    output logic                        step_o,
    output audio_pkg::level_t           level_l_o,
    output audio_pkg::level_t           level_r_o
);

    localparam int PW = `AUDIO_PERIOD_W;

    audio_pkg::count_t      per_q;          // clocks left until the next sample
    logic [PW:0]            per_dec;        // top bit is the borrow out
    logic                   step;

    audio_pkg::sample_t     sample_q;       // sample now playing
    audio_pkg::mix_state_t  state_q;

    // multiplier operands, registered in MIX_LOAD
    audio_pkg::sample_t     op_smp_q;
    audio_pkg::vol_t        op_vol_l_q;
    audio_pkg::vol_t        op_vol_r_q;

    logic signed [15:0]     prod_l;
    logic signed [15:0]     prod_r;

    assign per_dec = {1'b0, per_q} - 1'b1;
    assign step    = enable_i && per_dec[PW];   // counter underflows this cycle
    assign step_o  = step;

    // period timer and sample latch
    always_ff @(posedge clk) begin
        if (reset_i) begin
            per_q    <= '0;
            sample_q <= '0;
        end else if (!enable_i) begin
            per_q <= '0;                        // first step comes right after enable
        end else if (step) begin
            per_q    <= period_i;
            sample_q <= sample_i;               // byte consumed by the same pulse
        end else begin
            per_q <= per_dec[PW-1:0];
        end
    end

    // 64 is unity so bits 13..6 of the 8x8 signed products keep the sample scale
    assign prod_l = op_smp_q * op_vol_l_q;
    assign prod_r = op_smp_q * op_vol_r_q;

    always_ff @(posedge clk) begin
        op_smp_q   <= sample_q;
        op_vol_l_q <= vol_i.left;
        op_vol_r_q <= vol_i.right;
    end

    // levels move every other cycle in the two-phase mix
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= audio_pkg::MIX_LOAD;
            level_l_o <= '0;
            level_r_o <= '0;
        end else if (!enable_i) begin
            state_q   <= audio_pkg::MIX_LOAD;
            level_l_o <= audio_pkg::level_t'(vol_i.left);     // volume byte as a fixed level
            level_r_o <= audio_pkg::level_t'(vol_i.right);
        end else begin
            case (state_q)
                audio_pkg::MIX_LOAD: begin
                    state_q <= audio_pkg::MIX_SCALE;    // operands load this cycle
                end
                audio_pkg::MIX_SCALE: begin
                    state_q   <= audio_pkg::MIX_LOAD;
                    level_l_o <= prod_l[13:6] + 8'h80;  // signed to offset binary
                    level_r_o <= prod_r[13:6] + 8'h80;
                end
                default: begin
                    state_q <= audio_pkg::MIX_LOAD;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/audio_dac.sv
// first-order pulse-density DAC for one output pin that turns an unsigned level into pulses
`default_nettype none
`timescale 1ns/1ps

`include "audio_settings.svh"

module audio_dac #(
    parameter int WIDTH = `AUDIO_DAC_W
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic [WIDTH-1:0]   level_i,
    output logic                    pulse_o
);

    logic [WIDTH-1:0]   acc_q;          // error accumulator
    logic [WIDTH:0]     sum;            // top bit is the carry out

    assign sum = {1'b0, acc_q} + {1'b0, level_i};

    // carry rate equals level / 2**WIDTH
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q   <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc_q   <= sum[WIDTH-1:0];
            pulse_o <= sum[WIDTH];
        end
    end

endmodule

`default_nettype wire

// File: verilog/audio_top.sv
// one-channel playback top level that joins the fetch engine, the mixer and two DACs
`default_nettype none
`timescale 1ns/1ps

`include "audio_settings.svh"

module audio_top (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire audio_pkg::chan_cfg_t   cfg_i,
    input  wire logic                   enable_i,
    input  wire logic                   slot_start_i,
    input  wire logic                   slot_end_i,
    input  wire audio_pkg::word_t       word_i,
    output logic                        fetch_o,
    output audio_pkg::addr_t            addr_o,
    output logic                        pdm_l_o,
    output logic                        pdm_r_o
);

    audio_pkg::sample_t     sample;         // head byte of the fetch buffer
    logic                   step;           // mixer takes that byte
    audio_pkg::level_t      level_l;
    audio_pkg::level_t      level_r;

    audio_fetch fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .start_i        (cfg_i.start),
        .len_i          (cfg_i.len),
        .slot_start_i   (slot_start_i),
        .slot_end_i     (slot_end_i),
        .word_i         (word_i),
        .step_i         (step),
        .fetch_o        (fetch_o),
        .addr_o         (addr_o),
        .sample_o       (sample)
    );

    audio_mixer mixer (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .period_i       (cfg_i.period),
        .vol_i          (cfg_i.vol),
        .sample_i       (sample),
        .step_o         (step),
        .level_l_o      (level_l),
        .level_r_o      (level_r)
    );

    audio_dac #(
        .WIDTH          (`AUDIO_DAC_W)
    ) dac_l (
        .clk            (clk),
        .reset_i        (reset_i),
        .level_i        (level_l),
        .pulse_o        (pdm_l_o)
    );

    audio_dac #(
        .WIDTH          (`AUDIO_DAC_W)
    ) dac_r (
        .clk            (clk),
        .reset_i        (reset_i),
        .level_i        (level_r),
        .pulse_o        (pdm_r_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_audio_ref.svh
// expected-value model of the playback path that the testbench module includes
`ifndef TB_AUDIO_REF_SVH
`define TB_AUDIO_REF_SVH

// address requested after prev steps up or goes back to start past the last word
function automatic audio_pkg::addr_t ref_next_addr(
    input audio_pkg::addr_t     prev,
    input audio_pkg::addr_t     start,
    input audio_pkg::count_t    len
);
    audio_pkg::addr_t last;

    last = start + audio_pkg::addr_t'(len) - 16'd1;     // wraps at the top of memory
    if (prev == last) begin
        return start;
    end
    return prev + 16'd1;
endfunction

// volume 64 is unity, so the scaled sample is the product divided by 64
function automatic audio_pkg::level_t ref_level(
    input audio_pkg::sample_t   sample,
    input audio_pkg::vol_t      vol
);
    int prod;
    int scaled;

    prod   = int'(sample) * int'(vol);
    scaled = (prod >>> 6) + 128;                        // 128 is silence in offset binary
    return audio_pkg::level_t'(scaled & 255);
endfunction

`endif

// File: sim/tb_audio_top.sv
// testbench for audio_top that serves memory slots and checks requests and DAC levels
`default_nettype none
`timescale 1ns/1ps

module tb_audio_top;

    logic                   clk = 1'b0;
    logic                   reset_i;
    audio_pkg::chan_cfg_t   cfg_i;
    logic                   enable_i;
    logic                   slot_start_i;
    logic                   slot_end_i;
    audio_pkg::word_t       word_i;
    logic                   fetch_o;
    audio_pkg::addr_t       addr_o;
    logic                   pdm_l_o;
    logic                   pdm_r_o;

    audio_pkg::word_t       mem [0:65535];  // shared memory model
    int                     window_left = 0;
    int                     pulses_l;
    int                     pulses_r;

    `include "tb_audio_ref.svh"

    audio_top audio_top_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .cfg_i          (cfg_i),
        .enable_i       (enable_i),
        .slot_start_i   (slot_start_i),
        .slot_end_i     (slot_end_i),
        .word_i         (word_i),
        .fetch_o        (fetch_o),
        .addr_o         (addr_o),
        .pdm_l_o        (pdm_l_o),
        .pdm_r_o        (pdm_r_o)
    );

    always #10 clk = ~clk;

    // pdm outputs are stable at the falling edge
    always @(negedge clk) begin
        if (window_left > 0) begin
            pulses_l    += int'(pdm_l_o);
            pulses_r    += int'(pdm_r_o);
            window_left -= 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(input audio_pkg::addr_t exp, input audio_pkg::addr_t act,
                              input string what);
        if (act !== exp) begin
            $display("[ERROR] %0t ns: %s address expected %h, got %h", $time, what, exp, act);
            abort_run("request address mismatch");
        end
    endtask

    task automatic check_level(input audio_pkg::level_t exp, input audio_pkg::level_t act,
                               input string what);
        if (act !== exp) begin
            $display("[ERROR] %0t ns: %s level expected %0d, got %0d", $time, what, exp, act);
            abort_run("DAC level mismatch");
        end
    endtask

    task automatic check_flag(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            $display("[ERROR] %0t ns: %s expected %b, got %b", $time, what, exp, act);
            abort_run("fetch request mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                     // drive point after the edge
    endtask

    // one memory slot of 5 cycles with slot end 3 cycles after slot start
    task automatic run_slot(output logic raised, output audio_pkg::addr_t addr);
        raised = 1'b0;
        addr   = '0;
        slot_start_i = 1'b1;
        next_cycle();
        slot_start_i = 1'b0;
        for (int i = 0; i < 2; i++) begin
            raised |= fetch_o;
            next_cycle();
        end
        raised |= fetch_o;
        if (fetch_o) begin
            addr = addr_o;
        end
        slot_end_i = 1'b1;
        word_i     = mem[addr_o];
        next_cycle();
        slot_end_i = 1'b0;
        next_cycle();
    endtask

    // slots keep running while the DACs settle for 600 cycles and pulses are counted over 256
    task automatic measure_pdm(output int cnt_l, output int cnt_r);
        logic               raised;
        audio_pkg::addr_t   seen;
        int                 guard;

        for (int i = 0; i < 600; i += 5) begin
            run_slot(raised, seen);
        end
        pulses_l    = 0;
        pulses_r    = 0;
        window_left = 256;
        guard       = 0;
        while (window_left != 0) begin
            run_slot(raised, seen);
            guard++;
            if (guard > 100) begin
                abort_run("the 256-cycle pulse counting window never closed");
            end
        end
        cnt_l = pulses_l;
        cnt_r = pulses_r;
        if (cnt_l > 255 || cnt_r > 255) begin
            abort_run("a DAC pulsed in all 256 cycles, which no level can give");
        end
    endtask

    // play a region filled with one word and measure both DAC outputs
    task automatic play_word(input audio_pkg::word_t w, input audio_pkg::vol_t vl,
                             input audio_pkg::vol_t vr, output int cnt_l, output int cnt_r);
        enable_i = 1'b0;
        next_cycle();
        next_cycle();
        cfg_i.start     = audio_pkg::addr_t'($urandom);
        cfg_i.len       = audio_pkg::count_t'($urandom_range(6, 1));
        cfg_i.period    = 15'd20;
        cfg_i.vol.left  = vl;
        cfg_i.vol.right = vr;
        for (int i = 0; i < int'(cfg_i.len); i++) begin
            mem[audio_pkg::addr_t'(cfg_i.start + i)] = w;
        end
        enable_i = 1'b1;
        measure_pdm(cnt_l, cnt_r);
    endtask

    initial begin
        audio_pkg::addr_t   expect_addr;
        audio_pkg::addr_t   seen;
        audio_pkg::sample_t smp;
        audio_pkg::vol_t    vl;
        audio_pkg::vol_t    vr;
        logic               raised;
        int                 cnt_l;
        int                 cnt_r;
        int                 captures;
        int                 slots;

        void'($urandom(27044));
        reset_i      = 1'b1;
        cfg_i        = '0;
        enable_i     = 1'b0;
        slot_start_i = 1'b0;
        slot_end_i   = 1'b0;
        word_i       = '0;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = audio_pkg::word_t'(a) ^ 16'hc3a5;
        end
        repeat (4) next_cycle();
        reset_i = 1'b0;

        // volume bytes drive the DACs directly while disabled
        cfg_i.vol = audio_pkg::chan_vol_t'($urandom);
        measure_pdm(cnt_l, cnt_r);
        check_level(audio_pkg::level_t'(cfg_i.vol.left), audio_pkg::level_t'(cnt_l),
                    "bypass left");
        check_level(audio_pkg::level_t'(cfg_i.vol.right), audio_pkg::level_t'(cnt_r),
                    "bypass right");

        // address walk with wrap
        cfg_i.start  = audio_pkg::addr_t'($urandom);
        cfg_i.len    = audio_pkg::count_t'($urandom_range(6, 1));
        cfg_i.period = 15'd3;
        enable_i     = 1'b1;
        expect_addr  = cfg_i.start;
        captures     = 0;
        slots        = 0;
        while (captures < 20) begin
            run_slot(raised, seen);
            if (raised) begin
                check_addr(expect_addr, seen, "captured");
                expect_addr = ref_next_addr(expect_addr, cfg_i.start, cfg_i.len);
                captures++;
            end
            slots++;
            if (slots > 200) begin
                abort_run("fewer than 20 words were fetched within 200 memory slots");
            end
        end

        // re-enable goes back to start
        enable_i = 1'b0;
        next_cycle();
        cfg_i.start = cfg_i.start + 16'd8;      // outside the old region, so only a reload hits it
        next_cycle();
        enable_i = 1'b1;
        slots    = 0;
        raised   = 1'b0;
        while (!raised) begin
            run_slot(raised, seen);
            slots++;
            if (slots > 10) begin
                abort_run("no fetch request came after enable was raised again");
            end
        end
        check_addr(cfg_i.start, seen, "restart");

        // nothing is consumed with the longest period so the buffer fills
        enable_i = 1'b0;
        next_cycle();
        next_cycle();
        cfg_i.period = 15'h7fff;
        enable_i     = 1'b1;
        for (int s = 0; s < 6; s++) begin
            run_slot(raised, seen);
            check_flag(s < 3, raised, "fetch on slot with buffer state");
        end

        // volume scaling
        for (int t = 0; t < 4; t++) begin
            smp = audio_pkg::sample_t'($urandom);
            vl  = audio_pkg::vol_t'($urandom);
            vr  = audio_pkg::vol_t'($urandom);
            play_word({smp, smp}, vl, vr, cnt_l, cnt_r);
            check_level(ref_level(smp, vl), audio_pkg::level_t'(cnt_l), "scaled left");
            check_level(ref_level(smp, vr), audio_pkg::level_t'(cnt_r), "scaled right");
        end

        // silence and a negative sample at unity gain
        play_word(16'h0000, audio_pkg::vol_t'($urandom), audio_pkg::vol_t'($urandom),
                  cnt_l, cnt_r);
        check_level(8'h80, audio_pkg::level_t'(cnt_l), "silence left");
        check_level(8'h80, audio_pkg::level_t'(cnt_r), "silence right");
        smp = audio_pkg::sample_t'($urandom_range(255, 128));
        play_word({smp, smp}, 8'sd64, 8'sd64, cnt_l, cnt_r);
        check_level(audio_pkg::level_t'(smp) + 8'h80, audio_pkg::level_t'(cnt_l), "negative left");
        check_level(audio_pkg::level_t'(smp) + 8'h80, audio_pkg::level_t'(cnt_r), "negative right");

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+verilog
+incdir+sim
verilog/audio_pkg.sv
verilog/audio_fetch.sv
verilog/audio_mixer.sv
verilog/audio_dac.sv
verilog/audio_top.sv
sim/tb_audio_top.sv
